/* logic/xfer_pkg.sv */
package xfer_pkg;

   // word and memory sizes
   localparam int DATA_W     = 16;
   localparam int ADDR_W     = 4;
   localparam int FIFO_DEPTH = 1 << ADDR_W;

   // pointers carry one wrap bit above the address
   localparam int PTR_W = ADDR_W + 1;

   // burst length field
   localparam int LEN_W = 8;

   // how the source forms each word of a burst
   typedef enum logic [1:0] {
      op_ramp   = 2'd0,
      op_fill   = 2'd1,
      op_toggle = 2'd2
   } pattern_op_e;

   // command sampled with start
   // a length of zero produces no words
   typedef struct packed {
      pattern_op_e             op;
      logic [DATA_W-1:0]       seed;
      logic [LEN_W-1:0]        len;
   } burst_cmd_t;

   // running totals kept by the sink
   typedef struct packed {
      logic [DATA_W-1:0]       checksum;
      logic [15:0]             count;
   } sink_stat_t;

endpackage

/* logic/gray_counter.sv */
`timescale 1ns/1ps

module gray_counter
   import xfer_pkg::*;
(
   input  logic             clk,
   input  logic             rst,
   input  logic             en,
   output logic [PTR_W-1:0] bin,
   output logic [PTR_W-1:0] gray
);

   logic [PTR_W-1:0] bin_next;

   assign bin_next = bin + 1'b1;

   // gray copy is encoded from the next count, so both registers
   // always describe the same pointer value
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bin  <= '0;
         gray <= '0;
      end else if (en) begin
         bin  <= bin_next;
         gray <= bin_next ^ (bin_next >> 1);
      end
   end

endmodule

/* logic/dual_port_ram.sv */
`timescale 1ns/1ps

module dual_port_ram
   import xfer_pkg::*;
(
   // write port
   input  logic              wclk,
   input  logic              we,
   input  logic [ADDR_W-1:0] waddr,
   input  logic [DATA_W-1:0] wdata,

   // read port
   input  logic              rclk,
   input  logic              re,
   input  logic [ADDR_W-1:0] raddr,
   output logic [DATA_W-1:0] rdata
);

   logic [DATA_W-1:0] mem [FIFO_DEPTH];

   always_ff @(posedge wclk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
   end

   // output register holds its word until the next read
   always_ff @(posedge rclk) begin
      if (re) begin
         rdata <= mem[raddr];
      end
   end

endmodule

/* logic/async_fifo.sv */
`timescale 1ns/1ps

module async_fifo
   import xfer_pkg::*;
(
   input  logic              rst,

   // write side, wclk domain
   input  logic              wclk,
   input  logic              wr_en,
   input  logic [DATA_W-1:0] wr_data,
   output logic              full,
   output logic [PTR_W-1:0]  level_w,

   // read side, rclk domain
   input  logic              rclk,
   input  logic              rd_en,
   output logic [DATA_W-1:0] rd_data,
   output logic              empty,
   output logic [PTR_W-1:0]  level_r
);

   // write domain
   logic [PTR_W-1:0]       wbin;
   logic [PTR_W-1:0]       wgray;
   logic [1:0][PTR_W-1:0]  rgray_sync;
   logic [PTR_W-1:0]       rbin_sync;
   logic                   wr_en_int;

   // read domain
   logic [PTR_W-1:0]       rbin;
   logic [PTR_W-1:0]       rgray;
   logic [1:0][PTR_W-1:0]  wgray_sync;
   logic [PTR_W-1:0]       wbin_sync;
   logic                   rd_en_int;

   function automatic logic [PTR_W-1:0] gray2bin(input logic [PTR_W-1:0] g);
      logic [PTR_W-1:0] b;
      b[PTR_W-1] = g[PTR_W-1];
      for (int i = PTR_W-2; i >= 0; i--) begin
         b[i] = g[i] ^ b[i+1];
      end
      return b;
   endfunction

   // write side

   // overflow protection even if the producer misbehaves
   assign wr_en_int = wr_en & ~full;

   gray_counter u_wptr (
      .clk  (wclk),
      .rst  (rst),
      .en   (wr_en_int),
      .bin  (wbin),
      .gray (wgray)
   );

   // read pointer into wclk, two stages
   always_ff @(posedge wclk or posedge rst) begin
      if (rst) begin
         rgray_sync <= '0;
      end else begin
         rgray_sync[0] <= rgray;
         rgray_sync[1] <= rgray_sync[0];
      end
   end

   assign rbin_sync = gray2bin(rgray_sync[1]);

   // wrap bit makes the difference run 0..FIFO_DEPTH
   assign level_w = wbin - rbin_sync;
   assign full    = (level_w == PTR_W'(FIFO_DEPTH));

   // read side

   assign rd_en_int = rd_en & ~empty;

   gray_counter u_rptr (
      .clk  (rclk),
      .rst  (rst),
      .en   (rd_en_int),
      .bin  (rbin),
      .gray (rgray)
   );

   // write pointer into rclk, two stages
   always_ff @(posedge rclk or posedge rst) begin
      if (rst) begin
         wgray_sync <= '0;
      end else begin
         wgray_sync[0] <= wgray;
         wgray_sync[1] <= wgray_sync[0];
      end
   end

   assign wbin_sync = gray2bin(wgray_sync[1]);

   assign level_r = wbin_sync - rbin;
   assign empty   = (level_r == '0);

   // storage, addressed by the low bits of the binary pointers
   dual_port_ram u_ram (
      .wclk  (wclk),
      .we    (wr_en_int),
      .waddr (wbin[ADDR_W-1:0]),
      .wdata (wr_data),
      .rclk  (rclk),
      .re    (rd_en_int),
      .raddr (rbin[ADDR_W-1:0]),
      .rdata (rd_data)
   );

endmodule

/* logic/word_source.sv */
`timescale 1ns/1ps

module word_source
   import xfer_pkg::*;
(
   input  logic              wclk,
   input  logic              rst,
   input  logic              start,
   input  burst_cmd_t        cmd,
   input  logic              full,
   output logic              wr_en,
   output logic [DATA_W-1:0] wr_data,
   output logic              busy,
   output logic              done
);

   typedef enum logic [1:0] {
      idle   = 2'd0,
      run    = 2'd1,
      finish = 2'd2
   } src_state_e;

   src_state_e        state;
   burst_cmd_t        cmd_q;
   logic [LEN_W-1:0]  idx;
   logic [DATA_W-1:0] idx_ext;
   logic              last;

   // command is only captured from idle, a start while busy is dropped
   always_ff @(posedge wclk) begin
      if (state == idle && start) begin
         cmd_q <= cmd;
      end
   end

   assign last = (idx == cmd_q.len - 1'b1);

   always_ff @(posedge wclk or posedge rst) begin
      if (rst) begin
         state <= idle;
         idx   <= '0;
      end else begin
         case (state)
            idle: begin
               if (start) begin
                  idx   <= '0;
                  state <= (cmd.len == '0) ? finish : run;
               end
            end
            run: begin
               // full holds the index, that is the back-pressure
               if (wr_en) begin
                  idx <= idx + 1'b1;
                  if (last) begin
                     state <= finish;
                  end
               end
            end
            finish: state <= idle;
            default: state <= idle;
         endcase
      end
   end

   assign wr_en = (state == run) && !full;

   // done lasts the single finish cycle
   assign busy = (state == run);
   assign done = (state == finish);

   assign idx_ext = {{(DATA_W-LEN_W){1'b0}}, idx};

   // word pattern
   always_comb begin
      case (cmd_q.op)
         op_ramp:   wr_data = cmd_q.seed + idx_ext;
         op_fill:   wr_data = cmd_q.seed;
         op_toggle: wr_data = idx[0] ? ~cmd_q.seed : cmd_q.seed;
         default:   wr_data = cmd_q.seed;
      endcase
   end

endmodule

/* logic/word_sink.sv */
`timescale 1ns/1ps

module word_sink
   import xfer_pkg::*;
(
   input  logic              rclk,
   input  logic              rst,
   input  logic              drain,

   // FIFO read side
   input  logic              empty,
   output logic              rd_en,
   input  logic [DATA_W-1:0] rd_data,

   // output stream
   output logic              out_valid,
   output logic [DATA_W-1:0] out_data,
   output sink_stat_t        stat
);

   logic rd_pending;

   // one read per cycle while drain is up and data is there
   assign rd_en = drain & ~empty;

   // memory output register lands one cycle after the read
   always_ff @(posedge rclk or posedge rst) begin
      if (rst) begin
         rd_pending <= 1'b0;
      end else begin
         rd_pending <= rd_en;
      end
   end

   assign out_valid = rd_pending;
   assign out_data  = rd_data;

   // running totals, checksum wraps at 16 bits
   always_ff @(posedge rclk or posedge rst) begin
      if (rst) begin
         stat <= '0;
      end else if (out_valid) begin
         stat.checksum <= stat.checksum + out_data;
         stat.count    <= stat.count + 1'b1;
      end
   end

endmodule

/* logic/stream_bridge_top.sv */
`timescale 1ns/1ps

module stream_bridge_top
   import xfer_pkg::*;
(
   input  logic              wclk,
   input  logic              rclk,
   input  logic              rst,

   // command side, wclk
   input  logic              start,
   input  burst_cmd_t        cmd,
   output logic              busy,
   output logic              done,

   // stream side, rclk
   input  logic              drain,
   output logic              out_valid,
   output logic [DATA_W-1:0] out_data,
   output sink_stat_t        stat,

   // FIFO fill as seen from each domain
   output logic [PTR_W-1:0]  level_w,
   output logic [PTR_W-1:0]  level_r
);

   logic              wr_en;
   logic [DATA_W-1:0] wr_data;
   logic              full;
   logic              rd_en;
   logic [DATA_W-1:0] rd_data;
   logic              empty;

   word_source u_source (
      .wclk    (wclk),
      .rst     (rst),
      .start   (start),
      .cmd     (cmd),
      .full    (full),
      .wr_en   (wr_en),
      .wr_data (wr_data),
      .busy    (busy),
      .done    (done)
   );

   async_fifo u_fifo (
      .rst     (rst),
      .wclk    (wclk),
      .wr_en   (wr_en),
      .wr_data (wr_data),
      .full    (full),
      .level_w (level_w),
      .rclk    (rclk),
      .rd_en   (rd_en),
      .rd_data (rd_data),
      .empty   (empty),
      .level_r (level_r)
   );

   word_sink u_sink (
      .rclk      (rclk),
      .rst       (rst),
      .drain     (drain),
      .empty     (empty),
      .rd_en     (rd_en),
      .rd_data   (rd_data),
      .out_valid (out_valid),
      .out_data  (out_data),
      .stat      (stat)
   );

endmodule

/* tests/tb_tasks.svh */
task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
   if (actual !== expected) begin
      $display("ERR %s: expected %h, actual %h", name, expected, actual);
      err_count++;
   end
endtask

// word i of a burst, as the opcode defines it
function automatic logic [DATA_W-1:0] pattern_word(input pattern_op_e op,
                                                   input logic [DATA_W-1:0] s,
                                                   input int idx);
   case (op)
      op_ramp:   return s + idx[DATA_W-1:0];
      op_fill:   return s;
      op_toggle: return (idx % 2 == 1) ? ~s : s;
      default:   return s;
   endcase
endfunction

task automatic start_test(input string name);
   test_name    = name;
   err_at_start = err_count;
   tests_run++;
endtask

task automatic end_test();
   if (err_count == err_at_start) begin
      $display("test %s finished, ok", test_name);
   end else begin
      $display("test %s finished, %0d errors", test_name, err_count - err_at_start);
   end
endtask

// one-cycle start pulse, expected words queued first
task automatic issue_cmd(input pattern_op_e op, input logic [DATA_W-1:0] seed_val,
                         input logic [LEN_W-1:0] len, input bit expect_words);
   logic [DATA_W-1:0] w;
   if (expect_words) begin
      for (int i = 0; i < len; i++) begin
         w = pattern_word(op, seed_val, i);
         exp_q.push_back(w);
         exp_checksum = exp_checksum + w;
         exp_count    = exp_count + 1'b1;
      end
   end
   @(posedge wclk);
   #1;
   cmd.op   = op;
   cmd.seed = seed_val;
   cmd.len  = len;
   start    = 1'b1;
   @(posedge wclk);
   #1;
   start = 1'b0;
endtask

task automatic set_drain(input logic value);
   @(posedge rclk);
   #1;
   drain = value;
endtask

// busy must fall together with done
task automatic wait_done(input int limit);
   int n;
   n = 0;
   do begin
      @(negedge wclk);
      n++;
   end while (done !== 1'b1 && n < limit);
   if (done !== 1'b1) begin
      $display("%s: done pulse never arrived", test_name);
      err_count++;
   end else begin
      check_value(test_name, 32'd0, busy);
   end
endtask

task automatic wait_drained(input int limit);
   int n;
   n = 0;
   while (exp_q.size() != 0 && n < limit) begin
      @(negedge rclk);
      n++;
   end
   if (exp_q.size() != 0) begin
      $display("%s: %0d expected words never arrived", test_name, exp_q.size());
      err_count++;
   end
   // stat lands on the edge after the last valid
   repeat (3) @(negedge rclk);
endtask

task automatic check_stat();
   check_value(test_name, exp_count, stat.count);
   check_value(test_name, exp_checksum, stat.checksum);
endtask

task automatic test_reset_state();
   start_test("reset_state");
   @(negedge wclk);
   check_value(test_name, 32'd1, u_dut.u_fifo.empty);
   check_value(test_name, 32'd0, level_w);
   check_value(test_name, 32'd0, level_r);
   check_value(test_name, 32'd0, busy);
   check_value(test_name, 32'd0, done);
   check_value(test_name, 32'd0, out_valid);
   check_value(test_name, 32'd0, stat);
   end_test();
endtask

task automatic test_ramp_burst();
   start_test("ramp_burst");
   set_drain(1'b1);
   rnd_bits = $random(rnd_seed);
   issue_cmd(op_ramp, rnd_bits[DATA_W-1:0], 8'd10, 1'b1);
   wait_done(200);
   wait_drained(400);
   check_value(test_name, 32'd10, stat.count);
   check_stat();
   check_value(test_name, 32'd0, level_r);
   end_test();
endtask

// pointers start at 10, so both bursts cross a memory wrap
task automatic test_fill_toggle();
   start_test("fill_toggle");
   rnd_bits = $random(rnd_seed);
   issue_cmd(op_fill, rnd_bits[DATA_W-1:0], 8'd9, 1'b1);
   wait_done(200);
   rnd_bits = $random(rnd_seed);
   issue_cmd(op_toggle, rnd_bits[DATA_W-1:0], 8'd14, 1'b1);
   wait_done(200);
   wait_drained(400);
   check_stat();
   end_test();
endtask

task automatic test_back_pressure();
   int n;
   start_test("back_pressure");
   set_drain(1'b0);
   rnd_bits = $random(rnd_seed);
   issue_cmd(op_ramp, rnd_bits[DATA_W-1:0], 8'd24, 1'b1);
   n = 0;
   while (level_w != FIFO_DEPTH && n < 200) begin
      @(negedge wclk);
      n++;
   end
   repeat (10) @(negedge wclk);
   check_value(test_name, FIFO_DEPTH, level_w);
   check_value(test_name, 32'd1, busy);
   set_drain(1'b1);
   wait_done(300);
   wait_drained(400);
   check_stat();
   end_test();
endtask

task automatic test_random_drain();
   start_test("random_drain");
   stop_toggle = 1'b0;
   rnd_bits = $random(rnd_seed);
   issue_cmd(op_ramp, rnd_bits[DATA_W-1:0], 8'd40, 1'b1);
   fork
      begin
         wait_done(1000);
         wait_drained(1000);
         stop_toggle = 1'b1;
      end
      begin
         while (!stop_toggle) begin
            @(posedge rclk);
            #1;
            rnd_bits = $random(rnd_seed);
            drain    = rnd_bits[0];
         end
      end
   join
   set_drain(1'b1);
   check_stat();
   end_test();
endtask

task automatic test_zero_and_busy();
   start_test("zero_and_busy");
   issue_cmd(op_ramp, 16'h00aa, 8'd0, 1'b1);
   wait_done(20);
   repeat (10) @(negedge rclk);
   check_value(test_name, exp_count, stat.count);
   issue_cmd(op_fill, 16'h5a5a, 8'd6, 1'b1);
   check_value(test_name, 32'd1, busy);
   // lands mid-burst, so nothing is queued for it
   issue_cmd(op_toggle, 16'h1234, 8'd5, 1'b0);
   wait_done(100);
   wait_drained(200);
   repeat (20) @(negedge rclk);
   check_stat();
   end_test();
endtask

/* tests/tb_stream_bridge.sv */
`timescale 1ns/1ps

module tb_stream_bridge
   import xfer_pkg::*;
();

   // all bursts together times four, plus margin
   localparam int TIMEOUT_CYCLES = 4000;

   logic              wclk;
   logic              rclk;
   logic              rst;
   logic              start;
   burst_cmd_t        cmd;
   logic              busy;
   logic              done;
   logic              drain;
   logic              out_valid;
   logic [DATA_W-1:0] out_data;
   sink_stat_t        stat;
   logic [PTR_W-1:0]  level_w;
   logic [PTR_W-1:0]  level_r;

   // reference model state
   logic [DATA_W-1:0] exp_q[$];
   logic [DATA_W-1:0] exp_checksum;
   logic [15:0]       exp_count;
   logic [DATA_W-1:0] mon_word;

   string  test_name;
   int     err_count;
   int     err_at_start;
   int     tests_run;
   int     cycle_count;
   integer rnd_seed;
   integer rnd_bits;
   bit     stop_toggle;

   stream_bridge_top u_dut (
      .wclk      (wclk),
      .rclk      (rclk),
      .rst       (rst),
      .start     (start),
      .cmd       (cmd),
      .busy      (busy),
      .done      (done),
      .drain     (drain),
      .out_valid (out_valid),
      .out_data  (out_data),
      .stat      (stat),
      .level_w   (level_w),
      .level_r   (level_r)
   );

   `include "tb_tasks.svh"

   initial wclk = 1'b0;
   always #4 wclk = ~wclk;

   // unrelated to wclk
   initial rclk = 1'b0;
   always #5.5 rclk = ~rclk;

   // watchdog
   always @(posedge wclk) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout, run stopped after %0d wclk cycles in %s", cycle_count, test_name);
         $display("Simulation failed");
         $finish;
      end
   end

   // each output word against the head of the reference queue
   always @(negedge rclk) begin
      if (out_valid === 1'b1) begin
         if (exp_q.size() == 0) begin
            $display("%s: word received with empty expected queue (%h)", test_name, out_data);
            err_count++;
         end else begin
            mon_word = exp_q.pop_front();
            check_value(test_name, mon_word, out_data);
         end
      end
   end

   initial begin
      rst          = 1'b1;
      start        = 1'b0;
      cmd          = '0;
      drain        = 1'b0;
      exp_checksum = '0;
      exp_count    = '0;
      err_count    = 0;
      err_at_start = 0;
      tests_run    = 0;
      cycle_count  = 0;
      rnd_seed     = 32'h8bc3;
      stop_toggle  = 1'b0;
      test_name    = "reset";

      repeat (4) @(posedge wclk);
      #1 rst = 1'b0;

      test_reset_state();
      test_ramp_burst();
      test_fill_toggle();
      test_back_pressure();
      test_random_drain();
      test_zero_and_busy();

      $display("%0d tests run, %0d errors", tests_run, err_count);
      if (err_count == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* project.f */
+incdir+tests
logic/xfer_pkg.sv
logic/gray_counter.sv
logic/dual_port_ram.sv
logic/async_fifo.sv
logic/word_source.sv
logic/word_sink.sv
logic/stream_bridge_top.sv
tests/tb_stream_bridge.sv
